/* Bender.yml */
package:
  name: fetch_front_end

sources:
  - hw/fetch_pkg.sv
  - hw/return_stack.sv
  - hw/target_buffer.sv
  - hw/history_predictor.sv
  - hw/fetch_sequencer.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - verif/fetch_checker.sv
      - verif/fetch_tb.sv

/* hw/fetch_pkg.sv */
// shared widths, branch kinds and BTB entry layout for the fetch front end
// imported by every front-end module
package fetch_pkg;

  localparam int ADDR_W     = 32;
  localparam int OFFS_W     = 5;   // 32-byte fetch blocks
  localparam int GHT_W      = 8;
  localparam int PRED_IDX_W = 10;  // 1024 entries per direction table

  localparam int BLOCK_BYTES = 1 << OFFS_W;
  localparam int BTB_TAG_W   = ADDR_W - OFFS_W - 6;  // sized for the default 64-entry BTB

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [GHT_W-1:0]  ght_t;  // newest outcome in bit 0

  typedef enum logic [1:0] {
    BR_COND   = 2'd0,
    BR_UNCOND = 2'd1,
    BR_CALL   = 2'd2,
    BR_RET    = 2'd3
  } branch_kind_t;

  typedef struct packed {
    logic                 valid;
    logic [BTB_TAG_W-1:0] tag;
    branch_kind_t         kind;
    addr_t                target;
  } btb_entry_t;

  // drop the offset bits so the address points at the start of its block
  function automatic addr_t block_align(input addr_t addr);
    block_align = {addr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
  endfunction

endpackage

/* hw/fetch_sequencer.sv */
// fetch address and global history registers with next-block selection
// priority: interrupt, retire mispredict, BTB hit, sequential block
`timescale 1ns/1ps

module fetch_sequencer import fetch_pkg::*; #(
  parameter addr_t RESET_IP = 32'h0000_1000
) (
  input  logic         clk,
  input  logic         rst,

  input  logic         irq_load,
  input  addr_t        irq_ip,

  input  logic         retire_en,
  input  logic         retire_mispredict,
  input  logic         retire_taken,
  input  branch_kind_t retire_kind,
  input  addr_t        retire_src_ip,
  input  addr_t        retire_target,
  input  ght_t         retire_ght,

  input  logic         hit,
  input  branch_kind_t hit_kind,
  input  addr_t        hit_target,
  input  logic         pred_taken,
  input  addr_t        ras_top,

  output addr_t        fetch_ip,
  output ght_t         fetch_ght,

  output logic         ras_push,
  output addr_t        ras_push_addr,
  output logic         ras_pop
);

  addr_t seq_ip;
  addr_t next_ip;
  ght_t  next_ght;

  assign seq_ip = fetch_ip + addr_t'(BLOCK_BYTES);

  always_comb begin
    next_ip       = seq_ip;
    next_ght      = fetch_ght;
    ras_push      = 1'b0;
    ras_push_addr = seq_ip;
    ras_pop       = 1'b0;

    if (irq_load) begin
      next_ip       = block_align(irq_ip);
      ras_push      = 1'b1;
      ras_push_addr = fetch_ip;  // resume at the interrupted block
    end else if (retire_en && retire_mispredict) begin
      next_ip = retire_taken ? block_align(retire_target)
                             : block_align(retire_src_ip) + addr_t'(BLOCK_BYTES);
      if (retire_kind == BR_COND)
        next_ght = {retire_ght[GHT_W-2:0], retire_taken};
      else
        next_ght = retire_ght;
    end else if (hit) begin
      case (hit_kind)
        BR_RET: begin
          ras_pop = 1'b1;
          next_ip = block_align(ras_top);
        end
        BR_CALL: begin
          ras_push = 1'b1;  // fall-through is the default push address
          next_ip  = block_align(hit_target);
        end
        BR_UNCOND: next_ip = block_align(hit_target);
        default: begin  // conditional
          if (pred_taken)
            next_ip = block_align(hit_target);
          next_ght = {fetch_ght[GHT_W-2:0], pred_taken};
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_ip  <= RESET_IP;
      fetch_ght <= '0;
    end else begin
      fetch_ip  <= next_ip;
      fetch_ght <= next_ght;
    end
  end

endmodule

/* hw/fetch_top.sv */
// fetch-address front end: sequencer, BTB, direction predictor and return stack
// drive one block address per clock; retire and interrupt inputs are one-cycle strobes
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
  parameter addr_t RESET_IP    = 32'h0000_1000,
  parameter int    BTB_IDX_W   = 6,
  parameter int    RAS_DEPTH_W = 3
) (
  input  logic         clk,
  input  logic         rst,

  input  logic         irq_load,
  input  addr_t        irq_ip,

  input  logic         retire_en,
  input  addr_t        retire_src_ip,
  input  addr_t        retire_target,
  input  branch_kind_t retire_kind,
  input  logic         retire_taken,
  input  logic         retire_mispredict,
  input  ght_t         retire_ght,

  output addr_t        fetch_ip,
  output ght_t         fetch_ght
);

  logic         hit;
  branch_kind_t hit_kind;
  addr_t        hit_target;
  logic         pred_taken;
  addr_t        ras_top;
  logic         ras_push;
  addr_t        ras_push_addr;
  logic         ras_pop;

  fetch_sequencer #(
    .RESET_IP (RESET_IP)
  ) fetch_sequencer_inst (
    .clk               (clk),
    .rst               (rst),
    .irq_load          (irq_load),
    .irq_ip            (irq_ip),
    .retire_en         (retire_en),
    .retire_mispredict (retire_mispredict),
    .retire_taken      (retire_taken),
    .retire_kind       (retire_kind),
    .retire_src_ip     (retire_src_ip),
    .retire_target     (retire_target),
    .retire_ght        (retire_ght),
    .hit               (hit),
    .hit_kind          (hit_kind),
    .hit_target        (hit_target),
    .pred_taken        (pred_taken),
    .ras_top           (ras_top),
    .fetch_ip          (fetch_ip),
    .fetch_ght         (fetch_ght),
    .ras_push          (ras_push),
    .ras_push_addr     (ras_push_addr),
    .ras_pop           (ras_pop)
  );

  target_buffer #(
    .BTB_IDX_W (BTB_IDX_W)
  ) target_buffer_inst (
    .clk           (clk),
    .rst           (rst),
    .lookup_ip     (fetch_ip),
    .hit           (hit),
    .hit_kind      (hit_kind),
    .hit_target    (hit_target),
    .retire_en     (retire_en),
    .retire_taken  (retire_taken),
    .retire_src_ip (retire_src_ip),
    .retire_target (retire_target),
    .retire_kind   (retire_kind)
  );

  history_predictor history_predictor_inst (
    .clk               (clk),
    .rst               (rst),
    .lookup_ip         (fetch_ip),
    .lookup_ght        (fetch_ght),
    .pred_taken        (pred_taken),
    .retire_en         (retire_en),
    .retire_mispredict (retire_mispredict),
    .retire_kind       (retire_kind),
    .retire_src_ip     (retire_src_ip),
    .retire_ght        (retire_ght)
  );

  return_stack #(
    .RAS_DEPTH_W (RAS_DEPTH_W)
  ) return_stack_inst (
    .clk       (clk),
    .rst       (rst),
    .push      (ras_push),
    .push_addr (ras_push_addr),
    .pop       (ras_pop),
    .top       (ras_top)
  );

endmodule

/* hw/history_predictor.sv */
// conditional direction predictor: XOR of three one-bit tables with mixed indexing
// a conditional mispredict at retire flips one table entry, chosen round robin
`timescale 1ns/1ps

module history_predictor import fetch_pkg::*; (
  input  logic         clk,
  input  logic         rst,

  input  addr_t        lookup_ip,
  input  ght_t         lookup_ght,
  output logic         pred_taken,

  input  logic         retire_en,
  input  logic         retire_mispredict,
  input  branch_kind_t retire_kind,
  input  addr_t        retire_src_ip,
  input  ght_t         retire_ght
);

  localparam int TBL_SIZE = 1 << PRED_IDX_W;

  logic [TBL_SIZE-1:0]   tbl [3];
  logic [PRED_IDX_W-1:0] lk_idx [3];
  logic [PRED_IDX_W-1:0] upd_idx;
  logic [1:0]            flip_ptr;  // 0 = A, 1 = B, 2 = C
  logic                  flip_en;

  // A leans on address, C on history
  function automatic logic [PRED_IDX_W-1:0] table_index(input addr_t ip, input ght_t ght,
                                                        input logic [1:0] sel);
    case (sel)
      2'd0:    table_index = {ip[OFFS_W +: 8], ght[1:0]};
      2'd1:    table_index = {ip[OFFS_W +: 5], ght[4:0]};
      default: table_index = {ip[OFFS_W +: 2], ght[7:0]};
    endcase
  endfunction

  always_comb begin
    for (int t = 0; t < 3; t++)
      lk_idx[t] = table_index(lookup_ip, lookup_ght, 2'(t));
  end

  assign pred_taken = tbl[0][lk_idx[0]] ^ tbl[1][lk_idx[1]] ^ tbl[2][lk_idx[2]];

  assign upd_idx = table_index(retire_src_ip, retire_ght, flip_ptr);
  assign flip_en = retire_en && retire_mispredict && (retire_kind == BR_COND);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < 3; t++)
        tbl[t] <= '0;
      flip_ptr <= 2'd0;
    end else if (flip_en) begin
      tbl[flip_ptr][upd_idx] <= ~tbl[flip_ptr][upd_idx];  // inverts the XOR
      flip_ptr <= (flip_ptr == 2'd2) ? 2'd0 : flip_ptr + 2'd1;
    end
  end

endmodule

/* hw/return_stack.sv */
// circular return-address stack, top read combinationally
// overflow wraps onto the oldest entry
`timescale 1ns/1ps

module return_stack import fetch_pkg::*; #(
  parameter int RAS_DEPTH_W = 3
) (
  input  logic  clk,
  input  logic  rst,

  input  logic  push,
  input  addr_t push_addr,
  input  logic  pop,

  output addr_t top
);

  localparam int DEPTH = 1 << RAS_DEPTH_W;

  addr_t                  stack [DEPTH];
  logic [RAS_DEPTH_W-1:0] ptr;  // points at the current top
  logic [RAS_DEPTH_W-1:0] ptr_up;

  assign ptr_up = ptr + 1'b1;  // wraps
  assign top    = stack[ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
      for (int i = 0; i < DEPTH; i++)
        stack[i] <= '0;
    end else if (push) begin
      stack[ptr_up] <= push_addr;
      ptr           <= ptr_up;
    end else if (pop) begin
      ptr <= ptr - 1'b1;  // empty pop just moves on
    end
  end

endmodule

/* hw/target_buffer.sv */
// direct-mapped branch target buffer, combinational lookup by fetch block
// taken retires install or overwrite the entry at the source block's index
`timescale 1ns/1ps

module target_buffer import fetch_pkg::*; #(
  parameter int BTB_IDX_W = 6
) (
  input  logic         clk,
  input  logic         rst,

  input  addr_t        lookup_ip,
  output logic         hit,
  output branch_kind_t hit_kind,
  output addr_t        hit_target,

  input  logic         retire_en,
  input  logic         retire_taken,
  input  addr_t        retire_src_ip,
  input  addr_t        retire_target,
  input  branch_kind_t retire_kind
);

  localparam int ENTRIES = 1 << BTB_IDX_W;
  localparam int TAG_W   = ADDR_W - OFFS_W - BTB_IDX_W;

  btb_entry_t btb_mem [ENTRIES];
  btb_entry_t rd_entry;

  logic [BTB_IDX_W-1:0] lk_idx;
  logic [BTB_IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0]     lk_tag;
  logic [TAG_W-1:0]     wr_tag;

  assign lk_idx = lookup_ip[OFFS_W +: BTB_IDX_W];
  assign lk_tag = lookup_ip[ADDR_W-1 -: TAG_W];
  assign wr_idx = retire_src_ip[OFFS_W +: BTB_IDX_W];
  assign wr_tag = retire_src_ip[ADDR_W-1 -: TAG_W];

  assign rd_entry   = btb_mem[lk_idx];
  assign hit        = rd_entry.valid && (rd_entry.tag == BTB_TAG_W'(lk_tag));
  assign hit_kind   = rd_entry.kind;
  assign hit_target = rd_entry.target;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++)
        btb_mem[i].valid <= 1'b0;
    end else if (retire_en && retire_taken) begin
      btb_mem[wr_idx].valid  <= 1'b1;
      btb_mem[wr_idx].tag    <= BTB_TAG_W'(wr_tag);
      btb_mem[wr_idx].kind   <= retire_kind;
      btb_mem[wr_idx].target <= block_align(retire_target);
    end
  end

endmodule

/* src.f */
hw/fetch_pkg.sv
hw/return_stack.sv
hw/target_buffer.sv
hw/history_predictor.sv
hw/fetch_sequencer.sv
hw/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

/* verif/fetch_checker.sv */
// concurrent assertions on block alignment, return stack strobes and interrupt loads
// attached to every fetch sequencer through bind
`timescale 1ns/1ps

module fetch_checker import fetch_pkg::*; (
  input logic  clk,
  input logic  rst,
  input addr_t fetch_ip,
  input logic  ras_push,
  input logic  ras_pop,
  input logic  irq_load,
  input addr_t irq_ip
);

  int assert_fails = 0;

  a_block_aligned: assert property (@(posedge clk) disable iff (rst)
    fetch_ip[OFFS_W-1:0] == '0)
  else begin
    $error("fetch_ip %h has offset bits set", fetch_ip);
    assert_fails++;
  end

  a_push_pop_excl: assert property (@(posedge clk) disable iff (rst)
    !(ras_push && ras_pop))
  else begin
    $error("return stack push and pop in the same cycle");
    assert_fails++;
  end

  a_irq_target: assert property (@(posedge clk) disable iff (rst)
    irq_load |=> fetch_ip == ($past(irq_ip) & ~addr_t'(BLOCK_BYTES - 1)))
  else begin
    $error("fetch_ip %h does not follow the interrupt address", fetch_ip);
    assert_fails++;
  end

endmodule

bind fetch_sequencer fetch_checker fetch_checker_inst (.*);

/* verif/fetch_tb.sv */
// self-checking testbench for the fetch front end
// scripted retires and interrupts run against a cycle-level reference model, checked every cycle
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

  localparam addr_t RESET_IP       = 32'h0000_1000;
  localparam addr_t ALIGN_MASK     = 32'hffff_ffe0;
  localparam int    SCRIPT_CYCLES  = 5 + 10 + 14 + 28 + 95 + 16 + 13 + 2;
  localparam int    TIMEOUT_CYCLES = SCRIPT_CYCLES + 50;

  logic         clk, rst;
  logic         irq_load, retire_en, retire_taken, retire_mispredict;
  addr_t        irq_ip, retire_src_ip, retire_target;
  branch_kind_t retire_kind;
  ght_t         retire_ght;
  addr_t        fetch_ip;
  ght_t         fetch_ght;

  // reference model state
  addr_t        m_ip;
  ght_t         m_ght;
  logic         m_valid [64];
  addr_t        m_src [64];
  branch_kind_t m_kind [64];
  addr_t        m_tgt [64];
  logic         m_tbl [3][1024];
  int           m_flip;
  addr_t        m_stack [8];
  logic [2:0]   m_sp;

  logic         model_ready = 1'b0;
  logic [15:0]  lfsr_state  = 16'd80;
  int           cycle_count = 0;

  fetch_top fetch_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_take(input int nbits);
    logic        fb;
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [9:0] pred_idx(input addr_t ip, input ght_t ght, input int t);
    if (t == 0)
      return {ip[12:5], ght[1:0]};
    if (t == 1)
      return {ip[9:5], ght[4:0]};
    return {ip[6:5], ght};
  endfunction

  function automatic void model_reset();
    m_ip   = RESET_IP;
    m_ght  = '0;
    m_flip = 0;
    m_sp   = '0;
    for (int i = 0; i < 64; i++)
      m_valid[i] = 1'b0;
    for (int i = 0; i < 1024; i++)
      for (int t = 0; t < 3; t++)
        m_tbl[t][i] = 1'b0;
    for (int i = 0; i < 8; i++)
      m_stack[i] = '0;
  endfunction

  // lookups see the old tables and retire writes land after them
  function automatic void model_next();
    addr_t      seq, nxt, push_val;
    ght_t       ng;
    logic       hit, pred, push, pop;
    int         bi, wi;
    logic [9:0] fi;
    seq      = m_ip + 32'd32;
    nxt      = seq;
    ng       = m_ght;
    push     = 1'b0;
    pop      = 1'b0;
    push_val = seq;
    bi       = m_ip[10:5];
    hit      = m_valid[bi] && (m_src[bi][31:11] == m_ip[31:11]);
    pred     = m_tbl[0][pred_idx(m_ip, m_ght, 0)] ^ m_tbl[1][pred_idx(m_ip, m_ght, 1)]
             ^ m_tbl[2][pred_idx(m_ip, m_ght, 2)];
    if (irq_load) begin
      nxt      = irq_ip & ALIGN_MASK;
      push     = 1'b1;
      push_val = m_ip;
    end else if (retire_en && retire_mispredict) begin
      nxt = retire_taken ? (retire_target & ALIGN_MASK) : (retire_src_ip & ALIGN_MASK) + 32'd32;
      ng  = (retire_kind == BR_COND) ? {retire_ght[6:0], retire_taken} : retire_ght;
    end else if (hit) begin
      case (m_kind[bi])
        BR_RET: begin
          pop = 1'b1;
          nxt = m_stack[m_sp] & ALIGN_MASK;
        end
        BR_CALL: begin
          push = 1'b1;
          nxt  = m_tgt[bi];
        end
        BR_UNCOND: nxt = m_tgt[bi];
        default: begin
          if (pred)
            nxt = m_tgt[bi];
          ng = {m_ght[6:0], pred};
        end
      endcase
    end
    if (push) begin
      m_sp          = m_sp + 1'b1;  // wraps onto the oldest slot
      m_stack[m_sp] = push_val;
    end else if (pop) begin
      m_sp = m_sp - 1'b1;
    end
    if (retire_en && retire_taken) begin
      wi          = retire_src_ip[10:5];
      m_valid[wi] = 1'b1;
      m_src[wi]   = retire_src_ip;
      m_kind[wi]  = retire_kind;
      m_tgt[wi]   = retire_target & ALIGN_MASK;
    end
    if (retire_en && retire_mispredict && retire_kind == BR_COND) begin
      fi                 = pred_idx(retire_src_ip, retire_ght, m_flip);
      m_tbl[m_flip][fi]  = ~m_tbl[m_flip][fi];
      m_flip             = (m_flip == 2) ? 0 : m_flip + 1;
    end
    m_ip  = nxt;
    m_ght = ng;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      model_reset();
      model_ready = 1'b1;
    end else if (model_ready) begin
      model_next();
    end
  end

  always @(negedge clk) begin  // outputs settled mid-cycle
    if (model_ready) begin
      check_value("fetch_ip", fetch_ip, m_ip);
      check_value("fetch_ght", 32'(fetch_ght), 32'(m_ght));
      check_value("assertion failures",
                  fetch_top_inst.fetch_sequencer_inst.fetch_checker_inst.assert_fails, 0);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic drive_retire(input addr_t src, input addr_t tgt, input branch_kind_t kind,
                              input logic taken, input logic mispredict, input ght_t ght);
    retire_en         <= 1'b1;
    retire_src_ip     <= src;
    retire_target     <= tgt;
    retire_kind       <= kind;
    retire_taken      <= taken;
    retire_mispredict <= mispredict;
    retire_ght        <= ght;
  endtask

  task automatic retire_branch(input addr_t src, input addr_t tgt, input branch_kind_t kind,
                               input logic taken, input logic mispredict, input ght_t ght);
    @(posedge clk);
    drive_retire(src, tgt, kind, taken, mispredict, ght);
    @(posedge clk);
    retire_en <= 1'b0;
    irq_load  <= 1'b0;
  endtask

  // not-taken mispredict from the block before steers fetch without a BTB write or flip
  task automatic redirect_to(input addr_t ip, input ght_t ght);
    retire_branch(ip - 32'd32, '0, BR_UNCOND, 1'b0, 1'b1, ght);
  endtask

  initial begin
    addr_t a, b, call_blk, ret_blk;
    ght_t  g;
    rst = 1'b1;
    irq_load = 1'b0;
    irq_ip = '0;
    retire_en = 1'b0;
    retire_src_ip = '0;
    retire_target = '0;
    retire_kind = BR_COND;
    retire_taken = 1'b0;
    retire_mispredict = 1'b0;
    retire_ght = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    idle(10);  // sequential blocks

    a = 32'h0002_0000 | (lfsr_take(11) << 5);
    b = 32'h0003_0000 | lfsr_take(16);
    retire_branch(a, b, BR_UNCOND, 1'b1, 1'b0, '0);
    redirect_to(a, '0);
    idle(4);
    redirect_to(a ^ 32'h0000_0800, '0);  // same index, other tag
    idle(4);

    a = 32'h0002_0000 | (lfsr_take(11) << 5);
    b = 32'h0003_0000 | lfsr_take(16);
    g = lfsr_take(8);
    retire_branch(a, b, BR_COND, 1'b1, 1'b0, g);
    for (int i = 0; i < 3; i++) begin
      redirect_to(a, g);
      idle(3);
      retire_branch(a, b, BR_COND, 1'b1, 1'b1, g);  // flips A, then B, then C
    end
    redirect_to(a, g);
    idle(3);

    call_blk = 32'h0002_0000 | (lfsr_take(11) << 5);
    ret_blk  = 32'h0002_0000 | (lfsr_take(11) << 5);
    retire_branch(call_blk, ret_blk, BR_CALL, 1'b1, 1'b0, '0);
    retire_branch(ret_blk, '0, BR_RET, 1'b1, 1'b0, '0);
    redirect_to(call_blk, '0);
    idle(5);
    for (int i = 0; i < 10; i++) begin  // call chain deeper than the stack
      retire_branch(32'h0004_0000 + i * 64, 32'h0004_0000 + (i + 1) * 64, BR_CALL,
                    1'b1, 1'b0, '0);
      // every return address is itself a return block, so the unwind walks the whole stack
      retire_branch(32'h0004_0000 + i * 64 + 32, '0, BR_RET, 1'b1, 1'b0, '0);
    end
    retire_branch(32'h0004_0000 + 10 * 64, '0, BR_RET, 1'b1, 1'b0, '0);
    redirect_to(32'h0004_0000, '0);
    idle(40);

    for (int i = 0; i < 4; i++) begin
      a = 32'h0002_0000 | (lfsr_take(11) << 5);
      b = 32'h0003_0000 | lfsr_take(16);
      g = lfsr_take(8);
      retire_branch(a, b, (i < 2) ? BR_COND : BR_CALL, i[0], 1'b1, g);
      idle(2);
    end

    a = 32'h0002_0000 | (lfsr_take(11) << 5);
    b = 32'h0003_0000 | lfsr_take(16);
    @(posedge clk);
    drive_retire(a, b, BR_COND, 1'b1, 1'b1, lfsr_take(8));
    irq_load <= 1'b1;
    irq_ip   <= 32'h0008_0014;
    @(posedge clk);
    retire_en <= 1'b0;
    irq_load  <= 1'b0;
    retire_branch(ret_blk, '0, BR_RET, 1'b1, 1'b0, '0);  // reinstall the return block
    idle(1);
    redirect_to(ret_blk, '0);
    idle(6);

    idle(2);
    $display("TESTS PASSED");
    $finish;
  end

endmodule
